// ==== Bender.yml ====
package:
  name: ext_subsys

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/ext_subsys_pkg.sv
      - design/stream_fifo.sv
      - design/memcopy_regs.sv
      - design/memcopy_engine.sv
      - design/obi_arbiter.sv
      - design/slow_memory.sv
      - design/ext_subsys_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - test/tb_ext_subsys.sv

// ==== compile.f ====
+incdir+design
design/ext_subsys_pkg.sv
design/stream_fifo.sv
design/memcopy_regs.sv
design/memcopy_engine.sv
design/obi_arbiter.sv
design/slow_memory.sv
design/ext_subsys_top.sv
test/tb_ext_subsys.sv

// ==== design/ext_subsys_pkg.sv ====
// ------------------------------------------------
// Bus structs and small types shared by the
// copy peripheral and the slow memory
// ------------------------------------------------

`default_nettype none

package ext_subsys_pkg;

  typedef logic [31:0] word_t;

  typedef struct packed {
    logic        req;
    logic        we;
    logic [3:0]  be;
    logic [31:0] addr;
    logic [31:0] wdata;
  } obi_req_t;

  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic [31:0] rdata;
  } obi_rsp_t;

  typedef struct packed {
    logic        valid;
    logic        write;
    logic [31:0] addr;
    logic [31:0] wdata;
  } reg_req_t;

  typedef struct packed {
    logic        ready;
    logic        error;
    logic [31:0] rdata;
  } reg_rsp_t;

  // Byte addresses of word-aligned blocks, length in words
  typedef struct packed {
    logic [31:0] src;
    logic [31:0] dst;
    logic [15:0] len;
  } copy_cfg_t;

  typedef enum logic {
    access_read  = 1'b0,
    access_write = 1'b1
  } access_kind_e;

endpackage

`default_nettype wire

// ==== design/ext_subsys_settings.svh ====
// ------------------------------------------------
// Sizes and register offsets of the external
// device subsystem
// ------------------------------------------------

`ifndef EXT_SUBSYS_SETTINGS_SVH
`define EXT_SUBSYS_SETTINGS_SVH

// Word index comes from address bits [8:2]
`define EXT_MEM_WORDS 128
`define EXT_FIFO_DEPTH 4

`define EXT_REG_SRC 32'h0000_0000
`define EXT_REG_DST 32'h0000_0004
`define EXT_REG_LEN 32'h0000_0008
`define EXT_REG_CTRL 32'h0000_000C
`define EXT_REG_STATUS 32'h0000_0010

`endif

// ==== design/ext_subsys_top.sv ====
// ------------------------------------------------
// External device subsystem: copy peripheral,
// arbiter and slow memory
// ------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module ext_subsys_top (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  ext_subsys_pkg::reg_req_t reg_req_i,
  output ext_subsys_pkg::reg_rsp_t reg_rsp_o,
  input  ext_subsys_pkg::obi_req_t ext_obi_req_i,
  output ext_subsys_pkg::obi_rsp_t ext_obi_rsp_o,
  output logic                     memcopy_intr_o
);

  ext_subsys_pkg::copy_cfg_t copy_cfg;
  logic                      copy_start;
  logic                      copy_finish;
  ext_subsys_pkg::obi_req_t  engine_req;
  ext_subsys_pkg::obi_rsp_t  engine_rsp;
  ext_subsys_pkg::obi_req_t  mem_req;
  ext_subsys_pkg::obi_rsp_t  mem_rsp;

  memcopy_regs memcopy_regs_i (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .reg_req_i (reg_req_i),
    .reg_rsp_o (reg_rsp_o),
    .cfg_o     (copy_cfg),
    .start_o   (copy_start),
    .finish_i  (copy_finish),
    .intr_o    (memcopy_intr_o)
  );

  memcopy_engine memcopy_engine_i (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .cfg_i     (copy_cfg),
    .start_i   (copy_start),
    .finish_o  (copy_finish),
    .obi_req_o (engine_req),
    .obi_rsp_i (engine_rsp)
  );

  // External port is master 0, the engine master 1
  obi_arbiter obi_arbiter_i (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .m0_req_i (ext_obi_req_i),
    .m0_rsp_o (ext_obi_rsp_o),
    .m1_req_i (engine_req),
    .m1_rsp_o (engine_rsp),
    .s_req_o  (mem_req),
    .s_rsp_i  (mem_rsp)
  );

  slow_memory slow_memory_i (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (mem_req),
    .rsp_o   (mem_rsp)
  );

endmodule

`default_nettype wire

// ==== design/memcopy_engine.sv ====
// ------------------------------------------------
// Copy engine: read stage and write stage on one
// OBI master port, joined by a word FIFO
// ------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "ext_subsys_settings.svh"

module memcopy_engine (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  ext_subsys_pkg::copy_cfg_t cfg_i,
  input  logic                      start_i,
  output logic                      finish_o,
  output ext_subsys_pkg::obi_req_t  obi_req_o,
  input  ext_subsys_pkg::obi_rsp_t  obi_rsp_i
);

  localparam int unsigned cnt_w = $clog2(`EXT_FIFO_DEPTH + 1);

  logic                         busy_q;
  logic [31:0]                  rd_addr_q;
  logic [31:0]                  wr_addr_q;
  logic [15:0]                  rd_left_q;
  logic [15:0]                  wr_left_q;
  logic [15:0]                  ack_left_q;
  logic [cnt_w-1:0]             rd_out_q;
  logic                         hold_q;
  ext_subsys_pkg::access_kind_e hold_kind_q;
  logic [cnt_w:0]               in_flight;
  logic                         rd_ready;
  logic                         wr_ready;
  logic                         issue;
  ext_subsys_pkg::access_kind_e kind;
  logic                         granted;
  logic                         rd_grant;
  ext_subsys_pkg::word_t        data_head;
  logic                         data_empty;
  logic [cnt_w-1:0]             data_count;
  logic                         kind_full;
  ext_subsys_pkg::access_kind_e resp_kind;
  logic                         rd_rvalid;
  logic                         wr_rvalid;

  // Reads in flight plus words waiting must fit the FIFO
  assign in_flight = rd_out_q + data_count;
  assign rd_ready  = busy_q && (rd_left_q != '0) && !kind_full && (in_flight < `EXT_FIFO_DEPTH);
  assign wr_ready  = busy_q && (wr_left_q != '0) && !kind_full && !data_empty;

  // Writes first, and an ungranted request stays as it is
  always_comb begin
    if (hold_q) begin
      issue = 1'b1;
      kind  = hold_kind_q;
    end else if (wr_ready) begin
      issue = 1'b1;
      kind  = ext_subsys_pkg::access_write;
    end else begin
      issue = rd_ready;
      kind  = ext_subsys_pkg::access_read;
    end
  end

  assign obi_req_o.req   = issue;
  assign obi_req_o.we    = (kind == ext_subsys_pkg::access_write);
  assign obi_req_o.be    = 4'hF;
  assign obi_req_o.addr  = obi_req_o.we ? wr_addr_q : rd_addr_q;
  assign obi_req_o.wdata = obi_req_o.we ? data_head : '0;

  assign granted   = issue && obi_rsp_i.gnt;
  assign rd_grant  = granted && !obi_req_o.we;
  assign rd_rvalid = obi_rsp_i.rvalid && (resp_kind == ext_subsys_pkg::access_read);
  assign wr_rvalid = obi_rsp_i.rvalid && (resp_kind == ext_subsys_pkg::access_write);
  assign finish_o  = busy_q && (ack_left_q == '0);

  stream_fifo #(.item_t(ext_subsys_pkg::word_t)) data_fifo_i (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (rd_rvalid),
    .data_i  (obi_rsp_i.rdata),
    .pop_i   (granted && obi_req_o.we),
    .data_o  (data_head),
    .full_o  (),
    .empty_o (data_empty),
    .count_o (data_count)
  );

  // Kind of each granted request, to steer its rvalid
  stream_fifo #(.item_t(ext_subsys_pkg::access_kind_e)) kind_fifo_i (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (granted),
    .data_i  (kind),
    .pop_i   (obi_rsp_i.rvalid),
    .data_o  (resp_kind),
    .full_o  (kind_full),
    .empty_o (),
    .count_o ()
  );

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q      <= 1'b0;
      rd_addr_q   <= '0;
      wr_addr_q   <= '0;
      rd_left_q   <= '0;
      wr_left_q   <= '0;
      ack_left_q  <= '0;
      rd_out_q    <= '0;
      hold_q      <= 1'b0;
      hold_kind_q <= ext_subsys_pkg::access_read;
    end else if (start_i && !busy_q) begin
      busy_q     <= 1'b1;
      rd_addr_q  <= cfg_i.src;
      wr_addr_q  <= cfg_i.dst;
      rd_left_q  <= cfg_i.len;
      wr_left_q  <= cfg_i.len;
      ack_left_q <= cfg_i.len;
    end else if (busy_q) begin
      if (rd_grant) begin
        rd_addr_q <= rd_addr_q + 32'd4;
        rd_left_q <= rd_left_q - 1'b1;
      end else if (granted) begin
        wr_addr_q <= wr_addr_q + 32'd4;
        wr_left_q <= wr_left_q - 1'b1;
      end
      if (rd_grant && !rd_rvalid) rd_out_q <= rd_out_q + 1'b1;
      if (rd_rvalid && !rd_grant) rd_out_q <= rd_out_q - 1'b1;
      if (wr_rvalid) ack_left_q <= ack_left_q - 1'b1;
      hold_q      <= issue && !obi_rsp_i.gnt;
      hold_kind_q <= kind;
      if (finish_o) busy_q <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== design/memcopy_regs.sv ====
// ------------------------------------------------
// Copy configuration registers, status and
// interrupt of the memory-copy peripheral
// ------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "ext_subsys_settings.svh"

module memcopy_regs (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  ext_subsys_pkg::reg_req_t  reg_req_i,
  output ext_subsys_pkg::reg_rsp_t  reg_rsp_o,
  output ext_subsys_pkg::copy_cfg_t cfg_o,
  output logic                      start_o,
  input  logic                      finish_i,
  output logic                      intr_o
);

  logic [31:0] src_q;
  logic [31:0] dst_q;
  logic [15:0] len_q;
  logic        ie_q;
  logic        busy_q;
  logic        done_q;
  logic        wr_en;
  logic        hit;
  logic [31:0] rdata;

  assign wr_en = reg_req_i.valid && reg_req_i.write;

  always_comb begin
    hit   = 1'b1;
    rdata = '0;
    case (reg_req_i.addr)
      `EXT_REG_SRC:    rdata = src_q;
      `EXT_REG_DST:    rdata = dst_q;
      `EXT_REG_LEN:    rdata = {16'h0000, len_q};
      `EXT_REG_CTRL:   rdata = {30'd0, ie_q, 1'b0};
      `EXT_REG_STATUS: rdata = {30'd0, done_q, busy_q};
      default:         hit = 1'b0;
    endcase
  end

  // Answered in the request cycle
  assign reg_rsp_o.ready = reg_req_i.valid;
  assign reg_rsp_o.error = reg_req_i.valid && !hit;
  assign reg_rsp_o.rdata = rdata;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      src_q   <= '0;
      dst_q   <= '0;
      len_q   <= '0;
      ie_q    <= 1'b0;
      busy_q  <= 1'b0;
      done_q  <= 1'b0;
      start_o <= 1'b0;
    end else begin
      start_o <= 1'b0;
      if (wr_en && reg_req_i.addr == `EXT_REG_SRC) src_q <= reg_req_i.wdata;
      if (wr_en && reg_req_i.addr == `EXT_REG_DST) dst_q <= reg_req_i.wdata;
      if (wr_en && reg_req_i.addr == `EXT_REG_LEN) len_q <= reg_req_i.wdata[15:0];
      if (wr_en && reg_req_i.addr == `EXT_REG_STATUS && reg_req_i.wdata[1]) begin
        done_q <= 1'b0;
      end
      if (wr_en && reg_req_i.addr == `EXT_REG_CTRL) begin
        ie_q <= reg_req_i.wdata[1];
        // Start is dropped while a copy runs
        if (reg_req_i.wdata[0] && !busy_q) begin
          busy_q  <= 1'b1;
          done_q  <= 1'b0;
          start_o <= 1'b1;
        end
      end
      if (finish_i) begin
        busy_q <= 1'b0;
        done_q <= 1'b1;
      end
    end
  end

  assign cfg_o.src = src_q;
  assign cfg_o.dst = dst_q;
  assign cfg_o.len = len_q;
  assign intr_o    = done_q && ie_q;

endmodule

`default_nettype wire

// ==== design/obi_arbiter.sv ====
// ------------------------------------------------
// Round-robin OBI arbiter, two masters to one
// slave, with in-order response routing
// ------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module obi_arbiter (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  ext_subsys_pkg::obi_req_t m0_req_i,
  output ext_subsys_pkg::obi_rsp_t m0_rsp_o,
  input  ext_subsys_pkg::obi_req_t m1_req_i,
  output ext_subsys_pkg::obi_rsp_t m1_rsp_o,
  output ext_subsys_pkg::obi_req_t s_req_o,
  input  ext_subsys_pkg::obi_rsp_t s_rsp_i
);

  // Master that wins the next tie
  logic prio_q;
  logic lock_q;
  logic lock_sel_q;
  logic sel;
  logic sel_req;
  logic granted;
  logic tag_full;
  logic tag_head;

  always_comb begin
    if (lock_q) begin
      sel = lock_sel_q;
    end else if (m0_req_i.req && m1_req_i.req) begin
      sel = prio_q;
    end else begin
      sel = m1_req_i.req;
    end
  end

  assign sel_req = sel ? m1_req_i.req : m0_req_i.req;
  assign granted = s_req_o.req && s_rsp_i.gnt;

  always_comb begin
    s_req_o     = sel ? m1_req_i : m0_req_i;
    s_req_o.req = sel_req && !tag_full;
  end

  always_comb begin
    m0_rsp_o        = s_rsp_i;
    m1_rsp_o        = s_rsp_i;
    m0_rsp_o.gnt    = granted && !sel;
    m1_rsp_o.gnt    = granted && sel;
    m0_rsp_o.rvalid = s_rsp_i.rvalid && !tag_head;
    m1_rsp_o.rvalid = s_rsp_i.rvalid && tag_head;
  end

  // Route tag per grant, popped by its rvalid
  stream_fifo #(.item_t(logic)) route_fifo_i (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (granted),
    .data_i  (sel),
    .pop_i   (s_rsp_i.rvalid),
    .data_o  (tag_head),
    .full_o  (tag_full),
    .empty_o (),
    .count_o ()
  );

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      prio_q     <= 1'b0;
      lock_q     <= 1'b0;
      lock_sel_q <= 1'b0;
    end else begin
      if (granted) prio_q <= ~sel;
      // Keep the choice until the slave grants it
      lock_q     <= s_req_o.req && !s_rsp_i.gnt;
      lock_sel_q <= sel;
    end
  end

endmodule

`default_nettype wire

// ==== design/slow_memory.sv ====
// ------------------------------------------------
// Word memory with byte enables and a random
// grant delay of 0 to 3 cycles
// ------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "ext_subsys_settings.svh"

module slow_memory (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  ext_subsys_pkg::obi_req_t req_i,
  output ext_subsys_pkg::obi_rsp_t rsp_o
);

  localparam int unsigned idx_w = $clog2(`EXT_MEM_WORDS);

  ext_subsys_pkg::word_t mem_q [`EXT_MEM_WORDS];
  logic [7:0]            lfsr_q;
  logic                  waiting_q;
  logic [1:0]            wait_q;
  logic [1:0]            delay;
  logic                  gnt;
  logic [idx_w-1:0]      idx;
  logic                  rvalid_q;
  ext_subsys_pkg::word_t rdata_q;

  assign idx   = req_i.addr[idx_w+1:2];
  // Fresh delay from the LFSR, or what is left of the current one
  assign delay = waiting_q ? wait_q : lfsr_q[1:0];
  assign gnt   = req_i.req && (delay == 2'd0);

  assign rsp_o.gnt    = gnt;
  assign rsp_o.rvalid = rvalid_q;
  assign rsp_o.rdata  = rdata_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      lfsr_q    <= 8'hA5;
      waiting_q <= 1'b0;
      wait_q    <= '0;
      rvalid_q  <= 1'b0;
    end else begin
      lfsr_q    <= {lfsr_q[6:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
      waiting_q <= req_i.req && !gnt;
      wait_q    <= delay - 1'b1;
      rvalid_q  <= gnt;
    end
  end

  always_ff @(posedge clk_i) begin
    if (gnt) begin
      if (req_i.we) begin
        for (int b = 0; b < 4; b++) begin
          if (req_i.be[b]) mem_q[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
        end
        rdata_q <= '0;
      end else begin
        rdata_q <= mem_q[idx];
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/stream_fifo.sv ====
// ------------------------------------------------
// Circular-buffer FIFO with a type parameter
// ------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "ext_subsys_settings.svh"

module stream_fifo #(
  parameter type item_t = logic
) (
  input  logic                                  clk_i,
  input  logic                                  rst_n_i,
  input  logic                                  push_i,
  input  item_t                                 data_i,
  input  logic                                  pop_i,
  output item_t                                 data_o,
  output logic                                  full_o,
  output logic                                  empty_o,
  output logic [$clog2(`EXT_FIFO_DEPTH + 1)-1:0] count_o
);

  localparam int unsigned depth = `EXT_FIFO_DEPTH;
  localparam int unsigned ptr_w = (depth > 1) ? $clog2(depth) : 1;

  item_t            mem_q [depth];
  logic [ptr_w-1:0] wr_ptr_q;
  logic [ptr_w-1:0] rd_ptr_q;
  logic             do_push;
  logic             do_pop;

  assign full_o  = (count_o == depth);
  assign empty_o = (count_o == '0);
  assign data_o  = mem_q[rd_ptr_q];
  assign do_pop  = pop_i && !empty_o;
  // A full FIFO still takes a push when the head leaves in the same cycle
  assign do_push = push_i && (!full_o || do_pop);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_o  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == ptr_w'(depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == ptr_w'(depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) begin
        count_o <= count_o + 1'b1;
      end else if (do_pop && !do_push) begin
        count_o <= count_o - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

`default_nettype wire

// ==== test/tb_ext_subsys.sv ====
// ------------------------------------------------
// Directed testbench of the external subsystem
// with register, memory port, copy and interrupt tests
// ------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "ext_subsys_settings.svh"

module tb_ext_subsys;

  // Far above the memory fill and all copies together
  localparam int unsigned watchdog_cycles = 20000;

  logic                     clk;
  logic                     rst_n;
  ext_subsys_pkg::reg_req_t reg_req;
  ext_subsys_pkg::reg_rsp_t reg_rsp;
  ext_subsys_pkg::obi_req_t ext_req;
  ext_subsys_pkg::obi_rsp_t ext_rsp;
  logic                     memcopy_intr;
  logic                     intr_sample;
  logic [31:0]              model_mem [`EXT_MEM_WORDS];
  integer                   seed;

  ext_subsys_top dut (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .reg_req_i      (reg_req),
    .reg_rsp_o      (reg_rsp),
    .ext_obi_req_i  (ext_req),
    .ext_obi_rsp_o  (ext_rsp),
    .memcopy_intr_o (memcopy_intr)
  );

  always #4 clk = ~clk;

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  task automatic check_equal(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("MISMATCH at %0t: %s got 0x%08h expected 0x%08h",
                          $time, name, got, exp));
    end
  endtask

  function automatic logic is_mapped(input logic [31:0] addr);
    return (addr == `EXT_REG_SRC) || (addr == `EXT_REG_DST) || (addr == `EXT_REG_LEN) ||
           (addr == `EXT_REG_CTRL) || (addr == `EXT_REG_STATUS);
  endfunction

  // Word index from address bits [8:2]
  function automatic int word_index(input logic [31:0] addr);
    return int'(addr[8:2]);
  endfunction

  function automatic logic [31:0] fill_pattern(input logic [31:0] addr);
    return {~addr[15:0], addr[15:0]} ^ 32'h3C5A_0000 ^ {addr[31:16], 16'h0000};
  endfunction

  task automatic reg_access(input logic write, input logic [31:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    reg_req.valid = 1'b1;
    reg_req.write = write;
    reg_req.addr  = addr;
    reg_req.wdata = wdata;
    @(negedge clk);
    check_equal("reg_rsp.ready", {31'd0, reg_rsp.ready}, 32'd1);
    check_equal("reg_rsp.error", {31'd0, reg_rsp.error}, {31'd0, !is_mapped(addr)});
    rdata       = reg_rsp.rdata;
    intr_sample = memcopy_intr;
    next_cycle();
    reg_req = '0;
  endtask

  task automatic reg_write(input logic [31:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    reg_access(1'b1, addr, data, unused);
  endtask

  task automatic reg_read(input logic [31:0] addr, output logic [31:0] data);
    reg_access(1'b0, addr, 32'd0, data);
  endtask

  task automatic obi_access(input logic we, input logic [3:0] be, input logic [31:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    ext_req.req   = 1'b1;
    ext_req.we    = we;
    ext_req.be    = be;
    ext_req.addr  = addr;
    ext_req.wdata = wdata;
    @(negedge clk);
    while (!ext_rsp.gnt) @(negedge clk);
    next_cycle();
    ext_req = '0;
    @(negedge clk);
    while (!ext_rsp.rvalid) @(negedge clk);
    rdata = ext_rsp.rdata;
    next_cycle();
  endtask

  task automatic obi_write(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] be);
    logic [31:0] rd;
    obi_access(1'b1, be, addr, data, rd);
    check_equal("ext rdata of write", rd, 32'd0);
    for (int b = 0; b < 4; b++) begin
      if (be[b]) model_mem[word_index(addr)][8*b +: 8] = data[8*b +: 8];
    end
  endtask

  task automatic obi_read(input logic [31:0] addr, output logic [31:0] data);
    obi_access(1'b0, 4'hF, addr, 32'd0, data);
  endtask

  task automatic check_range(input logic [31:0] addr, input int words);
    logic [31:0] rd;
    for (int i = 0; i < words; i++) begin
      obi_read(addr + 4 * i, rd);
      check_equal($sformatf("mem[0x%03h]", addr + 4 * i), rd,
                  model_mem[word_index(addr + 4 * i)]);
    end
  endtask

  task automatic fill_random(input logic [31:0] addr, input int words);
    for (int i = 0; i < words; i++) begin
      obi_write(addr + 4 * i, $random(seed), 4'hF);
    end
  endtask

  // Intr must follow done and the enable on every poll
  task automatic poll_done(input logic ie);
    logic [31:0] status;
    status = '0;
    while (!status[1]) begin
      reg_read(`EXT_REG_STATUS, status);
      check_equal("memcopy_intr_o", {31'd0, intr_sample}, {31'd0, ie & status[1]});
    end
  endtask

  task automatic start_copy(input logic [31:0] src, input logic [31:0] dst,
                            input int len, input logic ie);
    logic [31:0] status;
    reg_write(`EXT_REG_SRC, src);
    reg_write(`EXT_REG_DST, dst);
    reg_write(`EXT_REG_LEN, len);
    reg_write(`EXT_REG_CTRL, {30'd0, ie, 1'b1});
    reg_read(`EXT_REG_STATUS, status);
    check_equal("status busy after start", {31'd0, status[0]}, 32'd1);
  endtask

  task automatic finish_copy(input logic [31:0] src, input logic [31:0] dst,
                             input int len, input logic ie);
    logic [31:0] status;
    poll_done(ie);
    check_equal("memcopy_intr_o at done", {31'd0, memcopy_intr}, {31'd0, ie});
    reg_write(`EXT_REG_STATUS, 32'h2);
    check_equal("memcopy_intr_o after clear", {31'd0, memcopy_intr}, 32'd0);
    reg_read(`EXT_REG_STATUS, status);
    check_equal("status after clear", status, 32'd0);
    for (int i = 0; i < len; i++) begin
      model_mem[word_index(dst + 4 * i)] = model_mem[word_index(src + 4 * i)];
    end
    // Destination plus one guard word on each side
    check_range(dst - 4, len + 2);
  endtask

  task automatic reset_state();
    logic [31:0] status;
    check_equal("ext gnt after reset", {31'd0, ext_rsp.gnt}, 32'd0);
    check_equal("ext rvalid after reset", {31'd0, ext_rsp.rvalid}, 32'd0);
    check_equal("engine req after reset", {31'd0, dut.engine_req.req}, 32'd0);
    check_equal("memcopy_intr_o after reset", {31'd0, memcopy_intr}, 32'd0);
    reg_read(`EXT_REG_STATUS, status);
    check_equal("status after reset", status, 32'd0);
  endtask

  task automatic register_readback();
    logic [31:0] rd;
    reg_write(`EXT_REG_SRC, 32'h1234_5678);
    reg_write(`EXT_REG_DST, 32'h9ABC_DEF0);
    reg_write(`EXT_REG_LEN, 32'h0000_0ABC);
    reg_write(`EXT_REG_CTRL, 32'h2);
    reg_read(`EXT_REG_SRC, rd);
    check_equal("SRC", rd, 32'h1234_5678);
    reg_read(`EXT_REG_DST, rd);
    check_equal("DST", rd, 32'h9ABC_DEF0);
    reg_read(`EXT_REG_LEN, rd);
    check_equal("LEN", rd, 32'h0000_0ABC);
    reg_read(`EXT_REG_CTRL, rd);
    check_equal("CTRL", rd, 32'h2);
    reg_write(`EXT_REG_CTRL, 32'h0);
    // Error flag is checked inside the access
    reg_read(32'h0000_0014, rd);
    reg_write(32'h0000_0020, 32'hFFFF_FFFF);
  endtask

  task automatic memory_port_rw();
    for (int i = 0; i < 8; i++) begin
      obi_write(4 * i, 32'hA5A5_0000 + i, 4'hF);
    end
    check_range(32'h000, 8);
    obi_write(32'h008, 32'h1122_3344, 4'b0101);
    obi_write(32'h00C, 32'hDEAD_BEEF, 4'b1000);
    obi_write(32'h010, 32'hCAFE_F00D, 4'b0110);
    obi_write(32'h014, 32'h0BAD_C0DE, 4'b0000);
    check_range(32'h000, 8);
  endtask

  task automatic copies_and_interrupts();
    fill_random(32'h040, 1);
    start_copy(32'h040, 32'h100, 1, 1'b0);
    finish_copy(32'h040, 32'h100, 1, 1'b0);
    fill_random(32'h048, 5);
    start_copy(32'h048, 32'h110, 5, 1'b1);
    finish_copy(32'h048, 32'h110, 5, 1'b1);
    fill_random(32'h060, 16);
    start_copy(32'h060, 32'h140, 16, 1'b0);
    finish_copy(32'h060, 32'h140, 16, 1'b0);
  endtask

  task automatic copy_during_traffic();
    fill_random(32'h0A0, 8);
    start_copy(32'h0A0, 32'h190, 8, 1'b1);
    fill_random(32'h020, 8);
    check_range(32'h020, 8);
    finish_copy(32'h0A0, 32'h190, 8, 1'b1);
  endtask

  task automatic start_while_busy();
    logic [31:0] status;
    start_copy(32'h060, 32'h1B8, 16, 1'b0);
    reg_write(`EXT_REG_SRC, 32'h0A0);
    reg_write(`EXT_REG_DST, 32'h0E0);
    reg_write(`EXT_REG_LEN, 32'd4);
    reg_write(`EXT_REG_CTRL, 32'h1);
    reg_read(`EXT_REG_STATUS, status);
    check_equal("status busy during copy", status, 32'h1);
    finish_copy(32'h060, 32'h1B8, 16, 1'b0);
    check_range(32'h0E0, 4);
  endtask

  task automatic zero_length_copy();
    start_copy(32'h0A0, 32'h0F0, 0, 1'b1);
    finish_copy(32'h0A0, 32'h0F0, 0, 1'b1);
    check_range(32'h0F4, 1);
  endtask

  initial begin
    seed        = 32'h29dd_7e16;
    clk         = 1'b0;
    rst_n       = 1'b0;
    reg_req     = '0;
    ext_req     = '0;
    intr_sample = 1'b0;
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    next_cycle();
    reset_state();
    for (int i = 0; i < `EXT_MEM_WORDS; i++) begin
      obi_write(4 * i, fill_pattern(4 * i), 4'hF);
    end
    register_readback();
    memory_port_rw();
    copies_and_interrupts();
    copy_during_traffic();
    start_while_busy();
    zero_length_copy();
    $display("ALL CHECKS PASSED");
    $finish;
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    abort_run("Timeout: the tests did not finish within the cycle limit");
  end

endmodule

`default_nettype wire
